/* src/ddr_cmd_pkg.sv */
`default_nettype none

package ddr_cmd_pkg;

	// command driven toward the dram
	typedef enum logic [2:0] {
		none        = 3'd0, // idle cycle
		activate    = 3'd1, // open a row
		read_cmd    = 3'd2, // column read
		write_cmd   = 3'd3, // column write
		precharge   = 3'd4, // close the row
		refresh_all = 3'd5  // all banks, rows must be closed
	} ddr_cmd_t;

	// direction of one request slot
	typedef enum logic {
		read  = 1'b0,
		write = 1'b1
	} req_type_t;

	// fill state of a burst buffer behind a slot
	typedef enum logic [2:0] {
		started_filling = 3'd0,
		almost_done     = 3'd1, // read may go
		full            = 3'd2, // write may go
		empty           = 3'd3, // nothing requested
		returning_data  = 3'd4  // already served
	} burst_state_t;

	localparam int BG_W   = 2;  // bank group address
	localparam int BANK_W = 2;  // bank inside group
	localparam int ROW_W  = 16; // row address

	localparam int BANKS  = 16; // flat bank id is {bg, bank}
	localparam int GROUPS = 4;

endpackage

`default_nettype wire

/* src/bank_timers.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_timers import ddr_cmd_pkg::*; #(
	parameter int T_ACT_COL    = 12,
	parameter int T_PRE_ACT    = 12,
	parameter int T_ACT_ACT_SB = 40,
	parameter int T_ACT_PRE    = 28,
	parameter int T_RD_PRE     = 6,
	parameter int T_WR_PRE     = 12,
	parameter int T_ACT_ACT_DB = 6
) (
	input  wire logic                            clk,
	input  wire logic                            rst_n,
	input  ddr_cmd_t                             pick_cmd, // command registered this edge
	input  wire logic [BG_W-1:0]                 pick_bg,
	input  wire logic [BANK_W-1:0]               pick_bank,
	input  wire logic [ROW_W-1:0]                pick_row,
	output logic      [BANKS-1:0]                row_open,
	output logic      [BANKS-1:0][ROW_W-1:0]     open_row,
	output logic      [BANKS-1:0]                act_ok,   // incl. group spacing
	output logic      [BANKS-1:0]                col_ok,
	output logic      [BANKS-1:0]                pre_ok
);

	localparam int ID_W     = BG_W + BANK_W;
	localparam int RST_WAIT = 5; // idle cycles before the first activate

	// activate counter serves three rules, saturate at the longest
	localparam int ACT_SAT_A = (T_ACT_ACT_SB > T_ACT_PRE) ? T_ACT_ACT_SB : T_ACT_PRE;
	localparam int ACT_SAT   = (ACT_SAT_A > T_ACT_COL) ? ACT_SAT_A : T_ACT_COL;

	localparam int ACT_W = $clog2(ACT_SAT + 1);
	localparam int RD_W  = $clog2(T_RD_PRE + 1);
	localparam int WR_W  = $clog2(T_WR_PRE + 1);
	localparam int PRE_W = $clog2(T_PRE_ACT + 1);
	localparam int GRP_W = $clog2(T_ACT_ACT_DB + 1);

	logic [ID_W-1:0]                pick_id;  // flat bank of the picked slot
	logic [BANKS-1:0]               bank_sel; // one-hot, only on a real command
	logic [BANKS-1:0][ACT_W-1:0]    act_cnt;  // cycles since activate
	logic [BANKS-1:0][RD_W-1:0]     rd_cnt;   // cycles since read
	logic [BANKS-1:0][WR_W-1:0]     wr_cnt;   // cycles since write
	logic [BANKS-1:0][PRE_W-1:0]    pre_cnt;  // cycles since precharge
	logic [GROUPS-1:0][GRP_W-1:0]   grp_cnt;  // cycles since activate in group

	assign pick_id = {pick_bg, pick_bank};

	always_comb begin
		bank_sel = '0;
		bank_sel[pick_id] = (pick_cmd != none); // refresh also lands here, harmless
	end

	// per-bank saturating counters
	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int b = 0; b < BANKS; b++) begin
				act_cnt[b] <= ACT_W'(T_ACT_ACT_SB - 1 - RST_WAIT); // delays first activate
				rd_cnt[b]  <= RD_W'(T_RD_PRE - 1);
				wr_cnt[b]  <= WR_W'(T_WR_PRE - 1);
				pre_cnt[b] <= PRE_W'(T_PRE_ACT - 1);
			end
		end else begin
			for (int b = 0; b < BANKS; b++) begin
				if (bank_sel[b] && pick_cmd == activate)
					act_cnt[b] <= '0;
				else if (act_cnt[b] != ACT_W'(ACT_SAT - 1))
					act_cnt[b] <= act_cnt[b] + 1'b1;

				if (bank_sel[b] && pick_cmd == read_cmd)
					rd_cnt[b] <= '0;
				else if (rd_cnt[b] != RD_W'(T_RD_PRE - 1))
					rd_cnt[b] <= rd_cnt[b] + 1'b1;

				if (bank_sel[b] && pick_cmd == write_cmd)
					wr_cnt[b] <= '0;
				else if (wr_cnt[b] != WR_W'(T_WR_PRE - 1))
					wr_cnt[b] <= wr_cnt[b] + 1'b1;

				if (bank_sel[b] && pick_cmd == precharge)
					pre_cnt[b] <= '0;
				else if (pre_cnt[b] != PRE_W'(T_PRE_ACT - 1))
					pre_cnt[b] <= pre_cnt[b] + 1'b1;
			end
		end
	end

	// activate spacing between banks of one group
	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int g = 0; g < GROUPS; g++)
				grp_cnt[g] <= GRP_W'(T_ACT_ACT_DB - 1);
		end else begin
			for (int g = 0; g < GROUPS; g++) begin
				if (pick_cmd == activate && pick_bg == BG_W'(g))
					grp_cnt[g] <= '0;
				else if (grp_cnt[g] != GRP_W'(T_ACT_ACT_DB - 1))
					grp_cnt[g] <= grp_cnt[g] + 1'b1;
			end
		end
	end

	// open-row flags
	always_ff @(posedge clk) begin
		if (rst_n) begin
			row_open <= '0;
		end else begin
			if (pick_cmd == refresh_all)
				row_open <= '0; // refresh closes everything
			else if (pick_cmd == activate)
				row_open[pick_id] <= 1'b1;
			else if (pick_cmd == precharge)
				row_open[pick_id] <= 1'b0;
		end
	end

	// row address, only meaningful while row_open is set
	always_ff @(posedge clk) begin
		if (pick_cmd == activate)
			open_row[pick_id] <= pick_row;
	end

	// counters reach param-1 one cycle before the command may appear on cmd
	always_comb begin
		for (int b = 0; b < BANKS; b++) begin
			act_ok[b] = pre_cnt[b] >= PRE_W'(T_PRE_ACT - 1) &&
			            act_cnt[b] >= ACT_W'(T_ACT_ACT_SB - 1) &&
			            grp_cnt[b >> BANK_W] >= GRP_W'(T_ACT_ACT_DB - 1);
			col_ok[b] = act_cnt[b] >= ACT_W'(T_ACT_COL - 1);
			pre_ok[b] = act_cnt[b] >= ACT_W'(T_ACT_PRE - 1) &&
			            rd_cnt[b] >= RD_W'(T_RD_PRE - 1) &&
			            wr_cnt[b] >= WR_W'(T_WR_PRE - 1);
		end
	end

endmodule

`default_nettype wire

/* src/bus_timers.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_timers import ddr_cmd_pkg::*; #(
	parameter int T_RD_DATA = 11,
	parameter int T_WR_DATA = 10,
	parameter int T_RD_WR   = 10,
	parameter int T_WR_RD   = 18,
	parameter int T_CCD     = 4,
	parameter int T_BURST   = 16,
	parameter int T_REFI    = 1000,
	parameter int T_RFC     = 20
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  ddr_cmd_t  pick_cmd,
	output logic      bus_free,      // last burst has left the data bus
	output logic      ccd_ok,        // column-to-column spacing met
	output logic      rd_turn_ok,    // write may follow the last read
	output logic      wr_turn_ok,    // read may follow the last write
	output req_type_t last_type,
	output logic      refresh_due,
	output logic      refresh_ready  // recovery after refresh done
);

	// long enough for every rule built on them
	localparam int RD_SAT = T_BURST + T_RD_DATA + T_CCD + T_RD_WR;
	localparam int WR_SAT = T_BURST + T_WR_DATA + T_CCD + T_WR_RD;

	localparam int RD_W  = $clog2(RD_SAT + 1);
	localparam int WR_W  = $clog2(WR_SAT + 1);
	localparam int REF_W = $clog2(T_REFI + 1);
	localparam int RFC_W = $clog2(T_RFC + 1);

	logic [RD_W-1:0]  rd_cnt;  // cycles since any read
	logic [WR_W-1:0]  wr_cnt;  // cycles since any write
	logic [REF_W-1:0] ref_cnt; // refresh interval
	logic [RFC_W-1:0] rfc_cnt; // refresh recovery

	always_ff @(posedge clk) begin
		if (rst_n) begin
			rd_cnt    <= RD_W'(RD_SAT - 1);
			wr_cnt    <= WR_W'(WR_SAT - 1);
			last_type <= read;
			ref_cnt   <= '0; // interval starts at reset
			rfc_cnt   <= RFC_W'(T_RFC - 1);
		end else begin
			if (pick_cmd == read_cmd)
				rd_cnt <= '0;
			else if (rd_cnt != RD_W'(RD_SAT - 1))
				rd_cnt <= rd_cnt + 1'b1;

			if (pick_cmd == write_cmd)
				wr_cnt <= '0;
			else if (wr_cnt != WR_W'(WR_SAT - 1))
				wr_cnt <= wr_cnt + 1'b1;

			if (pick_cmd == read_cmd)
				last_type <= read;
			else if (pick_cmd == write_cmd)
				last_type <= write;

			if (pick_cmd == refresh_all) begin
				ref_cnt <= '0;
				rfc_cnt <= '0;
			end else begin
				if (ref_cnt != REF_W'(T_REFI - 1))
					ref_cnt <= ref_cnt + 1'b1;
				if (rfc_cnt != RFC_W'(T_RFC - 1))
					rfc_cnt <= rfc_cnt + 1'b1;
			end
		end
	end

	assign bus_free = rd_cnt >= RD_W'(T_BURST + T_RD_DATA - 1) &&
	                  wr_cnt >= WR_W'(T_BURST + T_WR_DATA - 1);
	assign ccd_ok   = rd_cnt >= RD_W'(T_BURST + T_RD_DATA + T_CCD - 1) &&
	                  wr_cnt >= WR_W'(T_BURST + T_WR_DATA + T_CCD - 1);

	assign rd_turn_ok    = rd_cnt >= RD_W'(T_RD_WR - 1);
	assign wr_turn_ok    = wr_cnt >= WR_W'(T_WR_RD - 1);
	assign refresh_due   = ref_cnt >= REF_W'(T_REFI - 2); // leaves room to drain the bus
	assign refresh_ready = rfc_cnt >= RFC_W'(T_RFC - 1);

endmodule

`default_nettype wire

/* src/cmd_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_scheduler import ddr_cmd_pkg::*; #(
	parameter int NUM_SLOTS = 4,
	parameter int SLOT_W    = $clog2(NUM_SLOTS)
) (
	input  wire logic                               clk,
	input  wire logic                               rst_n,
	input  burst_state_t [NUM_SLOTS-1:0]            slot_state,
	input  req_type_t    [NUM_SLOTS-1:0]            slot_type,
	input  wire logic    [NUM_SLOTS-1:0][BG_W-1:0]  slot_bg,
	input  wire logic    [NUM_SLOTS-1:0][BANK_W-1:0] slot_bank,
	input  wire logic    [NUM_SLOTS-1:0][ROW_W-1:0] slot_row,
	input  wire logic    [BANKS-1:0]                row_open,
	input  wire logic    [BANKS-1:0][ROW_W-1:0]     open_row,
	input  wire logic    [BANKS-1:0]                act_ok,
	input  wire logic    [BANKS-1:0]                col_ok,
	input  wire logic    [BANKS-1:0]                pre_ok,
	input  wire logic                               bus_free,
	input  wire logic                               ccd_ok,
	input  wire logic                               rd_turn_ok,
	input  wire logic                               wr_turn_ok,
	input  req_type_t                               last_type,
	input  wire logic                               refresh_due,
	input  wire logic                               refresh_ready,
	output ddr_cmd_t                                pick_cmd,  // combinational choice
	output logic         [BG_W-1:0]                 pick_bg,
	output logic         [BANK_W-1:0]               pick_bank,
	output logic         [ROW_W-1:0]                pick_row,
	output ddr_cmd_t                                cmd,       // registered, one-cycle strobe
	output logic         [SLOT_W-1:0]               cmd_slot
);

	localparam int ID_W = BG_W + BANK_W;

	logic     [NUM_SLOTS-1:0][ID_W-1:0] bank_id;   // flat bank per slot
	logic     [NUM_SLOTS-1:0]           turn_ok;   // direction change allowed
	logic     [NUM_SLOTS-1:0]           elig;      // slot has a legal command
	ddr_cmd_t [NUM_SLOTS-1:0]           slot_cmd;  // that command
	logic     [SLOT_W-1:0]              start_idx; // slot after the last served
	logic     [SLOT_W-1:0]              pick_slot;
	logic                               pick_found;

	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			bank_id[i] = {slot_bg[i], slot_bank[i]};
			// same direction, or the opposite one has waited long enough
			turn_ok[i] = (slot_type[i] == last_type) ||
			             (last_type == read ? rd_turn_ok : wr_turn_ok);
		end
	end

	// eligibility, only from an idle cycle with the bus drained
	always_comb begin
		elig     = '0;
		for (int i = 0; i < NUM_SLOTS; i++)
			slot_cmd[i] = none;
		if (cmd == none && bus_free && refresh_ready) begin
			if (refresh_due) begin
				elig[0]     = 1'b1; // refresh rides on slot 0
				slot_cmd[0] = refresh_all;
			end else begin
				for (int i = 0; i < NUM_SLOTS; i++) begin
					if (slot_state[i] != empty && slot_state[i] != returning_data) begin
						if (!row_open[bank_id[i]]) begin
							if (act_ok[bank_id[i]]) begin // bank closed, open it
								elig[i]     = 1'b1;
								slot_cmd[i] = activate;
							end
						end else if (open_row[bank_id[i]] != slot_row[i]) begin
							if (pre_ok[bank_id[i]]) begin // row conflict
								elig[i]     = 1'b1;
								slot_cmd[i] = precharge;
							end
						end else if (turn_ok[i] && ccd_ok && col_ok[bank_id[i]]) begin
							if (slot_type[i] == read &&
							    (slot_state[i] == almost_done || slot_state[i] == full)) begin
								elig[i]     = 1'b1;
								slot_cmd[i] = read_cmd;
							end else if (slot_type[i] == write && slot_state[i] == full) begin
								elig[i]     = 1'b1;
								slot_cmd[i] = write_cmd;
							end
						end
					end
				end
			end
		end
	end

	// round robin, first eligible slot at or after start_idx
	always_comb begin
		int idx;
		pick_found = 1'b0;
		pick_slot  = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			idx = (int'(start_idx) + k) % NUM_SLOTS;
			if (!pick_found && elig[idx]) begin
				pick_found = 1'b1;
				pick_slot  = SLOT_W'(idx);
			end
		end
	end

	assign pick_cmd  = pick_found ? slot_cmd[pick_slot] : none;
	assign pick_bg   = slot_bg[pick_slot];
	assign pick_bank = slot_bank[pick_slot];
	assign pick_row  = slot_row[pick_slot];

	always_ff @(posedge clk) begin
		if (rst_n) begin
			cmd       <= none;
			cmd_slot  <= '0;
			start_idx <= '0;
		end else begin
			cmd      <= pick_cmd;
			cmd_slot <= pick_slot;
			if (pick_cmd != none) // wrap past the last slot
				start_idx <= (pick_slot == SLOT_W'(NUM_SLOTS - 1)) ? '0 : pick_slot + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/timing_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module timing_controller import ddr_cmd_pkg::*; #(
	parameter int NUM_SLOTS    = 4,
	parameter int T_ACT_COL    = 12, // activate to read/write
	parameter int T_PRE_ACT    = 12,
	parameter int T_ACT_ACT_SB = 40, // same bank
	parameter int T_ACT_PRE    = 28,
	parameter int T_RD_DATA    = 11,
	parameter int T_WR_DATA    = 10,
	parameter int T_RD_PRE     = 6,
	parameter int T_WR_PRE     = 12,
	parameter int T_ACT_ACT_DB = 6,  // different bank, same group
	parameter int T_RD_WR      = 10,
	parameter int T_WR_RD      = 18,
	parameter int T_CCD        = 4,
	parameter int T_BURST      = 16,
	parameter int T_REFI       = 1000,
	parameter int T_RFC        = 20
) (
	input  wire logic                                 clk,
	input  wire logic                                 rst_n,
	input  burst_state_t [NUM_SLOTS-1:0]              slot_state,
	input  req_type_t    [NUM_SLOTS-1:0]              slot_type,
	input  wire logic    [NUM_SLOTS-1:0][BG_W-1:0]    slot_bg,
	input  wire logic    [NUM_SLOTS-1:0][BANK_W-1:0]  slot_bank,
	input  wire logic    [NUM_SLOTS-1:0][ROW_W-1:0]   slot_row,
	output ddr_cmd_t                                  cmd,
	output logic         [$clog2(NUM_SLOTS)-1:0]      cmd_slot
);

	ddr_cmd_t                   pick_cmd;
	logic [BG_W-1:0]            pick_bg;
	logic [BANK_W-1:0]          pick_bank;
	logic [ROW_W-1:0]           pick_row;
	logic [BANKS-1:0]           row_open;
	logic [BANKS-1:0][ROW_W-1:0] open_row;
	logic [BANKS-1:0]           act_ok;
	logic [BANKS-1:0]           col_ok;
	logic [BANKS-1:0]           pre_ok;
	logic                       bus_free;
	logic                       ccd_ok;
	logic                       rd_turn_ok;
	logic                       wr_turn_ok;
	req_type_t                  last_type;
	logic                       refresh_due;
	logic                       refresh_ready;

	bank_timers #(
		.T_ACT_COL(T_ACT_COL), .T_PRE_ACT(T_PRE_ACT), .T_ACT_ACT_SB(T_ACT_ACT_SB),
		.T_ACT_PRE(T_ACT_PRE), .T_RD_PRE(T_RD_PRE), .T_WR_PRE(T_WR_PRE),
		.T_ACT_ACT_DB(T_ACT_ACT_DB)
	) u_bank_timers (
		.clk(clk), .rst_n(rst_n),
		.pick_cmd(pick_cmd), .pick_bg(pick_bg), .pick_bank(pick_bank), .pick_row(pick_row),
		.row_open(row_open), .open_row(open_row),
		.act_ok(act_ok), .col_ok(col_ok), .pre_ok(pre_ok)
	);

	bus_timers #(
		.T_RD_DATA(T_RD_DATA), .T_WR_DATA(T_WR_DATA), .T_RD_WR(T_RD_WR),
		.T_WR_RD(T_WR_RD), .T_CCD(T_CCD), .T_BURST(T_BURST),
		.T_REFI(T_REFI), .T_RFC(T_RFC)
	) u_bus_timers (
		.clk(clk), .rst_n(rst_n), .pick_cmd(pick_cmd),
		.bus_free(bus_free), .ccd_ok(ccd_ok),
		.rd_turn_ok(rd_turn_ok), .wr_turn_ok(wr_turn_ok), .last_type(last_type),
		.refresh_due(refresh_due), .refresh_ready(refresh_ready)
	);

	cmd_scheduler #(
		.NUM_SLOTS(NUM_SLOTS)
	) u_cmd_scheduler (
		.clk(clk), .rst_n(rst_n),
		.slot_state(slot_state), .slot_type(slot_type),
		.slot_bg(slot_bg), .slot_bank(slot_bank), .slot_row(slot_row),
		.row_open(row_open), .open_row(open_row),
		.act_ok(act_ok), .col_ok(col_ok), .pre_ok(pre_ok),
		.bus_free(bus_free), .ccd_ok(ccd_ok),
		.rd_turn_ok(rd_turn_ok), .wr_turn_ok(wr_turn_ok), .last_type(last_type),
		.refresh_due(refresh_due), .refresh_ready(refresh_ready),
		.pick_cmd(pick_cmd), .pick_bg(pick_bg), .pick_bank(pick_bank), .pick_row(pick_row),
		.cmd(cmd), .cmd_slot(cmd_slot)
	);

endmodule

`default_nettype wire

/* verif/ddr_protocol_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_protocol_checker import ddr_cmd_pkg::*; #(
	parameter int NUM_SLOTS    = 4,
	parameter int T_ACT_COL    = 12,
	parameter int T_PRE_ACT    = 12,
	parameter int T_ACT_ACT_SB = 40,
	parameter int T_ACT_PRE    = 28,
	parameter int T_RD_DATA    = 11,
	parameter int T_WR_DATA    = 10,
	parameter int T_RD_PRE     = 6,
	parameter int T_WR_PRE     = 12,
	parameter int T_ACT_ACT_DB = 6,
	parameter int T_RD_WR      = 10,
	parameter int T_WR_RD      = 18,
	parameter int T_CCD        = 4,
	parameter int T_BURST      = 16,
	parameter int T_REFI       = 1000,
	parameter int T_RFC        = 20
) (
	input  wire logic                                clk,
	input  wire logic                                rst_n,
	input  ddr_cmd_t                                 cmd,
	input  wire logic    [$clog2(NUM_SLOTS)-1:0]     cmd_slot,
	input  burst_state_t [NUM_SLOTS-1:0]             slot_state,
	input  req_type_t    [NUM_SLOTS-1:0]             slot_type,
	input  wire logic    [NUM_SLOTS-1:0][BG_W-1:0]   slot_bg,
	input  wire logic    [NUM_SLOTS-1:0][BANK_W-1:0] slot_bank,
	input  wire logic    [NUM_SLOTS-1:0][ROW_W-1:0]  slot_row,
	output logic                                     error,     // latched on first failure
	output int                                       cmd_count  // non-idle commands seen
);

	localparam int SLOT_W   = $clog2(NUM_SLOTS);
	localparam int RST_WAIT = 5;       // extra idle cycles before first activate
	localparam int REF_MAX  = T_REFI + T_BURST + T_RD_DATA + T_WR_RD;
	localparam int NEVER    = -100000; // far in the past

	burst_state_t [NUM_SLOTS-1:0]             snap_state; // inputs the DUT decided on
	req_type_t    [NUM_SLOTS-1:0]             snap_type;
	logic         [NUM_SLOTS-1:0][BG_W+BANK_W-1:0] snap_bank; // flat {bg, bank}
	logic         [NUM_SLOTS-1:0][ROW_W-1:0]  snap_row;
	logic                                     m_open [BANKS];   // model row state
	logic         [ROW_W-1:0]                 m_row [BANKS];
	int                                       last_act [BANKS];
	int                                       last_rd [BANKS];
	int                                       last_wr [BANKS];
	int                                       last_pre [BANKS];
	int                                       last_grp [GROUPS]; // group activates
	int                                       last_rd_any;
	int                                       last_wr_any;
	int                                       last_cmd;
	int                                       last_rfc;
	int                                       ref_mark;  // last refresh, or reset release
	int                                       cyc = 0;
	req_type_t                                last_dir;  // direction of last column
	logic                                     first_done;

	task automatic check_cmd(input ddr_cmd_t got, input ddr_cmd_t want, input string what);
		if (got != want && !error) begin
			$display("Mismatch at %0t: %s, got %s expected %s", $time, what,
			         got.name(), want.name());
			error = 1'b1;
		end
	endtask

	task automatic check_slot(input logic [SLOT_W-1:0] got, input logic [SLOT_W-1:0] want,
	                          input string what);
		if (got != want && !error) begin
			$display("Mismatch at %0t: %s, got slot %0d expected slot %0d", $time, what,
			         got, want);
			error = 1'b1;
		end
	endtask

	task automatic check_gap(input int gap, input int min_gap, input string what);
		if (gap < min_gap && !error) begin
			$display("Mismatch at %0t: %s, gap %0d below %0d cycles", $time, what, gap, min_gap);
			error = 1'b1;
		end
	endtask

	// what a slot may legally ask for, given the model's bank state
	function automatic ddr_cmd_t expected_cmd(input int s);
		int b;
		b = int'(snap_bank[s]);
		if (snap_state[s] == empty || snap_state[s] == returning_data)
			return none; // not requesting
		if (!m_open[b])
			return activate;
		if (m_row[b] != snap_row[s])
			return precharge; // row conflict
		if (snap_type[s] == read && (snap_state[s] == almost_done || snap_state[s] == full))
			return read_cmd;
		if (snap_type[s] == write && snap_state[s] == full)
			return write_cmd;
		return none;
	endfunction

	// sampled mid-cycle, cmd here was decided from the previous snapshot
	always @(negedge clk) begin
		int b;
		int g;
		int s;
		ddr_cmd_t want;
		cyc++;
		if (rst_n) begin
			error       = 1'b0;
			cmd_count   = 0;
			last_rd_any = NEVER;
			last_wr_any = NEVER;
			last_cmd    = NEVER;
			last_rfc    = NEVER;
			ref_mark    = cyc + 1; // interval counts from the release edge
			last_dir    = read;
			first_done  = 1'b0;
			for (int i = 0; i < BANKS; i++) begin
				m_open[i]   = 1'b0;
				last_act[i] = NEVER;
				last_rd[i]  = NEVER;
				last_wr[i]  = NEVER;
				last_pre[i] = NEVER;
			end
			for (int i = 0; i < GROUPS; i++)
				last_grp[i] = NEVER;
			check_cmd(cmd, none, "command during reset");
			check_slot(cmd_slot, SLOT_W'(0), "slot during reset");
		end else if (!error) begin
			if (cyc - ref_mark > REF_MAX) begin
				$display("refresh missing for more than %0d cycles at %0t", REF_MAX, $time);
				error = 1'b1;
			end
			if (cmd != none) begin
				s = int'(cmd_slot);
				b = int'(snap_bank[s]);
				g = b >> BANK_W;
				cmd_count++;
				if (!first_done)
					check_gap(cyc - ref_mark, RST_WAIT + 1, "first command after reset");
				first_done = 1'b1;
				check_gap(cyc - last_cmd, 2, "command to command");
				check_gap(cyc - last_rfc, T_RFC, "refresh recovery");
				check_gap(cyc - last_rd_any, T_BURST + T_RD_DATA, "data bus after read");
				check_gap(cyc - last_wr_any, T_BURST + T_WR_DATA, "data bus after write");
				if (cyc - ref_mark >= T_REFI - 1) begin
					want = refresh_all; // nothing else once due
					check_slot(cmd_slot, SLOT_W'(0), "refresh slot");
				end else begin
					want = expected_cmd(s);
				end
				check_cmd(cmd, want, "issued command");
				case (cmd)
					activate: begin
						check_gap(cyc - last_act[b], T_ACT_ACT_SB, "activate same bank");
						check_gap(cyc - last_pre[b], T_PRE_ACT, "precharge to activate");
						check_gap(cyc - last_grp[g], T_ACT_ACT_DB, "activate same group");
						m_open[b]   = 1'b1;
						m_row[b]    = snap_row[s];
						last_act[b] = cyc;
						last_grp[g] = cyc;
					end
					precharge: begin
						check_gap(cyc - last_act[b], T_ACT_PRE, "activate to precharge");
						check_gap(cyc - last_rd[b], T_RD_PRE, "read to precharge");
						check_gap(cyc - last_wr[b], T_WR_PRE, "write to precharge");
						m_open[b]   = 1'b0;
						last_pre[b] = cyc;
					end
					read_cmd, write_cmd: begin
						check_gap(cyc - last_act[b], T_ACT_COL, "activate to column");
						check_gap(cyc - last_rd_any, T_BURST + T_RD_DATA + T_CCD,
						          "column after read");
						check_gap(cyc - last_wr_any, T_BURST + T_WR_DATA + T_CCD,
						          "column after write");
						if (cmd == read_cmd && last_dir == write)
							check_gap(cyc - last_wr_any, T_WR_RD, "write to read turnaround");
						if (cmd == write_cmd && last_dir == read)
							check_gap(cyc - last_rd_any, T_RD_WR, "read to write turnaround");
						if (cmd == read_cmd) begin
							last_rd[b]  = cyc;
							last_rd_any = cyc;
							last_dir    = read;
						end else begin
							last_wr[b]  = cyc;
							last_wr_any = cyc;
							last_dir    = write;
						end
					end
					refresh_all: begin
						for (int i = 0; i < BANKS; i++)
							m_open[i] = 1'b0; // all banks closed
						ref_mark = cyc;
						last_rfc = cyc;
					end
					default: begin
					end
				endcase
				last_cmd = cyc;
			end
		end
		for (int i = 0; i < NUM_SLOTS; i++) begin
			snap_state[i] = slot_state[i];
			snap_type[i]  = slot_type[i];
			snap_bank[i]  = {slot_bg[i], slot_bank[i]};
			snap_row[i]   = slot_row[i];
		end
	end

endmodule

`default_nettype wire

/* verif/tb_timing_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_timing_controller import ddr_cmd_pkg::*; ();

	localparam int NUM_SLOTS     = 4;
	localparam int T_ACT_COL     = 12;
	localparam int T_PRE_ACT     = 12;
	localparam int T_ACT_ACT_SB  = 40;
	localparam int T_ACT_PRE     = 28;
	localparam int T_RD_DATA     = 11;
	localparam int T_WR_DATA     = 10;
	localparam int T_RD_PRE      = 6;
	localparam int T_WR_PRE      = 12;
	localparam int T_ACT_ACT_DB  = 6;
	localparam int T_RD_WR       = 10;
	localparam int T_WR_RD       = 18;
	localparam int T_CCD         = 4;
	localparam int T_BURST       = 16;
	localparam int T_REFI        = 1000;
	localparam int T_RFC         = 20;
	localparam int N_CMDS        = 3000;   // commands before the run ends
	localparam int RUN_TIMEOUT   = 400000; // cycles
	localparam int SERVE_TIMEOUT = 2000;   // cycles a live slot may wait

	logic                                     clk;
	logic                                     rst_n;
	burst_state_t [NUM_SLOTS-1:0]             slot_state;
	req_type_t    [NUM_SLOTS-1:0]             slot_type;
	logic         [NUM_SLOTS-1:0][BG_W-1:0]   slot_bg;
	logic         [NUM_SLOTS-1:0][BANK_W-1:0] slot_bank;
	logic         [NUM_SLOTS-1:0][ROW_W-1:0]  slot_row;
	ddr_cmd_t                                 cmd;
	logic         [$clog2(NUM_SLOTS)-1:0]     cmd_slot;
	logic                                     chk_error;
	int                                       cmd_count;
	logic                                     serve_error;
	int                                       wait_cnt [NUM_SLOTS];  // cycles since fill
	int                                       refill_in [NUM_SLOTS]; // idle cycles left

	timing_controller #(
		.NUM_SLOTS(NUM_SLOTS), .T_ACT_COL(T_ACT_COL), .T_PRE_ACT(T_PRE_ACT),
		.T_ACT_ACT_SB(T_ACT_ACT_SB), .T_ACT_PRE(T_ACT_PRE), .T_RD_DATA(T_RD_DATA),
		.T_WR_DATA(T_WR_DATA), .T_RD_PRE(T_RD_PRE), .T_WR_PRE(T_WR_PRE),
		.T_ACT_ACT_DB(T_ACT_ACT_DB), .T_RD_WR(T_RD_WR), .T_WR_RD(T_WR_RD),
		.T_CCD(T_CCD), .T_BURST(T_BURST), .T_REFI(T_REFI), .T_RFC(T_RFC)
	) uut (
		.clk(clk), .rst_n(rst_n),
		.slot_state(slot_state), .slot_type(slot_type),
		.slot_bg(slot_bg), .slot_bank(slot_bank), .slot_row(slot_row),
		.cmd(cmd), .cmd_slot(cmd_slot)
	);

	ddr_protocol_checker #(
		.NUM_SLOTS(NUM_SLOTS), .T_ACT_COL(T_ACT_COL), .T_PRE_ACT(T_PRE_ACT),
		.T_ACT_ACT_SB(T_ACT_ACT_SB), .T_ACT_PRE(T_ACT_PRE), .T_RD_DATA(T_RD_DATA),
		.T_WR_DATA(T_WR_DATA), .T_RD_PRE(T_RD_PRE), .T_WR_PRE(T_WR_PRE),
		.T_ACT_ACT_DB(T_ACT_ACT_DB), .T_RD_WR(T_RD_WR), .T_WR_RD(T_WR_RD),
		.T_CCD(T_CCD), .T_BURST(T_BURST), .T_REFI(T_REFI), .T_RFC(T_RFC)
	) u_checker (
		.clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_slot(cmd_slot),
		.slot_state(slot_state), .slot_type(slot_type),
		.slot_bg(slot_bg), .slot_bank(slot_bank), .slot_row(slot_row),
		.error(chk_error), .cmd_count(cmd_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// new request, one row per bank among live slots so they never fight
	task automatic fill_slot(input int s);
		slot_bg[s]    = BG_W'($urandom_range(0, GROUPS - 1));
		slot_bank[s]  = BANK_W'($urandom_range(0, 3));
		slot_row[s]   = ROW_W'($urandom_range(0, 3) * 'h0a51); // few rows, many hits
		slot_type[s]  = req_type_t'($urandom_range(0, 1));
		slot_state[s] = burst_state_t'($urandom_range(0, 2)); // started_filling..full
		for (int o = 0; o < NUM_SLOTS; o++)
			if (o != s && slot_state[o] != empty &&
			    slot_bg[o] == slot_bg[s] && slot_bank[o] == slot_bank[s])
				slot_row[s] = slot_row[o];
		wait_cnt[s] = 0;
	endtask

	// one cycle of slot activity, run just after the clock edge
	task automatic step_slots();
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if ((cmd == read_cmd || cmd == write_cmd) && int'(cmd_slot) == s) begin
				slot_state[s] = empty; // served
				refill_in[s]  = $urandom_range(1, 6);
			end else if (slot_state[s] == empty) begin
				if (refill_in[s] == 0)
					fill_slot(s);
				else
					refill_in[s]--;
			end else begin
				wait_cnt[s]++;
				if (wait_cnt[s] > SERVE_TIMEOUT && !serve_error) begin
					$display("slot %0d was not served within %0d cycles", s, SERVE_TIMEOUT);
					serve_error = 1'b1;
				end
				if (slot_state[s] != full && $urandom_range(0, 3) == 0) // buffer fills up
					slot_state[s] = (slot_state[s] == started_filling) ? almost_done : full;
			end
		end
	endtask

	initial begin
		int cyc;
		void'($urandom(84842));
		rst_n       = 1'b1; // active high
		serve_error = 1'b0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			slot_state[s] = empty;
			slot_type[s]  = read;
			slot_bg[s]    = '0;
			slot_bank[s]  = '0;
			slot_row[s]   = '0;
			refill_in[s]  = 0;
			wait_cnt[s]   = 0;
		end
		for (cyc = 0; cyc < 10; cyc++)
			@(posedge clk);
		#1;
		rst_n = 1'b0;
		for (int s = 0; s < NUM_SLOTS; s++)
			fill_slot(s);
		cyc = 0;
		while (cyc < RUN_TIMEOUT && cmd_count < N_CMDS && !chk_error && !serve_error) begin
			@(posedge clk);
			#1;
			step_slots();
			cyc++;
		end
		if (chk_error || serve_error || cmd_count < N_CMDS) begin
			if (!chk_error && !serve_error)
				$display("timeout after %0d cycles with %0d commands seen", cyc, cmd_count);
			$display("TEST FAIL");
			$fatal(1, "run stopped on the first error");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* files.f */
src/ddr_cmd_pkg.sv
src/bank_timers.sv
src/bus_timers.sv
src/cmd_scheduler.sv
src/timing_controller.sv
verif/ddr_protocol_checker.sv
verif/tb_timing_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the timing controller testbench with verilator

cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module tb_timing_controller \
	-f files.f -Mdir "$OBJ" -o sim_tb; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -qx "TEST PASS" "$LOG"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see $LOG"
exit 1
